/* common/rom_pkg.sv */
`default_nettype none

// shared widths and request/response types for the boot ROM subsystem.
package rom_pkg;

    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    // one read request from a requester, held until its response arrives.
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } rom_req_t;

    // one-cycle answer to a granted read.
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } rom_rsp_t;

    // requester ids, also the round-robin order.
    typedef enum logic [1:0] {
        REQ_HOST = 2'd0,
        REQ_HDR  = 2'd1,
        REQ_SUM  = 2'd2
    } req_id_e;

endpackage

`default_nettype wire

/* rom/program_rom.sv */
`timescale 1ns/1ps
`default_nettype none

// boot image, 128 bytes, one registered read per clock.
module program_rom (
    input  wire logic                       clk,
    input  wire logic                       enable,
    input  wire logic [rom_pkg::ADDR_W-1:0] addr,
    output logic      [rom_pkg::DATA_W-1:0] data
);

    logic [rom_pkg::DATA_W-1:0] data_q;

    always_ff @(posedge clk) begin
        case (addr)
            7'h00: data_q <= 8'h41;
            7'h01: data_q <= 8'h53;
            7'h02: data_q <= 8'h52;
            7'h03: data_q <= 8'h4D;
            7'h04: data_q <= 8'h28;
            7'h05: data_q <= 8'h1C;
            7'h06: data_q <= 8'h21;
            7'h07: data_q <= 8'h8C;
            7'h08: data_q <= 8'h6D;
            7'h09: data_q <= 8'h9C;
            7'h0A: data_q <= 8'h8C;
            7'h0B: data_q <= 8'h6D;
            7'h0C: data_q <= 8'h1D;
            7'h0D: data_q <= 8'h24;
            7'h0E: data_q <= 8'h1C;
            7'h0F: data_q <= 8'h28;
            7'h10: data_q <= 8'h8C;
            7'h11: data_q <= 8'h1C;
            7'h12: data_q <= 8'h24;
            7'h13: data_q <= 8'h5C;
            7'h14: data_q <= 8'h11;
            7'h15: data_q <= 8'h20;
            7'h16: data_q <= 8'h70;
            7'h17: data_q <= 8'h12;
            7'h18: data_q <= 8'hC1;
            7'h19: data_q <= 8'h21;
            7'h1A: data_q <= 8'h31;
            7'h1B: data_q <= 8'h11;
            7'h1C: data_q <= 8'h02;
            7'h1D: data_q <= 8'hC1;
            7'h1E: data_q <= 8'h21;
            7'h1F: data_q <= 8'h31;
            7'h20: data_q <= 8'h11;
            7'h21: data_q <= 8'h02;
            7'h22: data_q <= 8'hC1;
            7'h23: data_q <= 8'h21;
            7'h24: data_q <= 8'h31;
            7'h25: data_q <= 8'h11;
            7'h26: data_q <= 8'h02;
            7'h27: data_q <= 8'hC1;
            7'h28: data_q <= 8'h21;
            7'h29: data_q <= 8'h31;
            7'h2A: data_q <= 8'h11;
            7'h2B: data_q <= 8'h21;
            7'h2C: data_q <= 8'hC1;
            7'h2D: data_q <= 8'h31;
            7'h2E: data_q <= 8'h11;
            7'h2F: data_q <= 8'h22;
            7'h30: data_q <= 8'hC1;
            7'h31: data_q <= 8'h21;
            7'h32: data_q <= 8'h31;
            7'h33: data_q <= 8'h11;
            7'h34: data_q <= 8'h21;
            7'h35: data_q <= 8'h31;
            7'h36: data_q <= 8'h11;
            7'h37: data_q <= 8'h0D;
            7'h38: data_q <= 8'h1B;
            7'h39: data_q <= 8'h28;
            7'h3A: data_q <= 8'h1C;
            7'h3B: data_q <= 8'h21;
            7'h3C: data_q <= 8'h8C;
            7'h3D: data_q <= 8'h6D;
            7'h3E: data_q <= 8'h9C;
            7'h3F: data_q <= 8'h8C;
            7'h40: data_q <= 8'h6D;
            7'h41: data_q <= 8'h1D;
            7'h42: data_q <= 8'h21;
            7'h43: data_q <= 8'h1C;
            7'h44: data_q <= 8'h22;
            7'h45: data_q <= 8'h3C;
            7'h46: data_q <= 8'h3E;
            7'h47: data_q <= 8'h1E;
            7'h48: data_q <= 8'h74;
            7'h49: data_q <= 8'h23;
            7'h4A: data_q <= 8'h3C;
            7'h4B: data_q <= 8'hE5;
            7'h4C: data_q <= 8'h3E;
            7'h4D: data_q <= 8'hD0;
            7'h4E: data_q <= 8'h1C;
            7'h4F: data_q <= 8'h0B;
            7'h50: data_q <= 8'h1D;
            7'h51: data_q <= 8'h0C;
            7'h52: data_q <= 8'hEE;
            7'h53: data_q <= 8'h28;
            7'h54: data_q <= 8'h1D;
            7'h55: data_q <= 8'h0D;
            7'h56: data_q <= 8'h1B;
            7'h57: data_q <= 8'h28;
            7'h58: data_q <= 8'h1C;
            7'h59: data_q <= 8'h21;
            7'h5A: data_q <= 8'h8C;
            7'h5B: data_q <= 8'h6D;
            7'h5C: data_q <= 8'h9C;
            7'h5D: data_q <= 8'h8C;
            7'h5E: data_q <= 8'h6D;
            7'h5F: data_q <= 8'h1D;
            7'h60: data_q <= 8'h21;
            7'h61: data_q <= 8'h1C;
            7'h62: data_q <= 8'h22;
            7'h63: data_q <= 8'h3C;
            7'h64: data_q <= 8'h3E;
            7'h65: data_q <= 8'h1E;
            7'h66: data_q <= 8'h70;
            7'h67: data_q <= 8'h23;
            7'h68: data_q <= 8'h3C;
            7'h69: data_q <= 8'hE5;
            7'h6A: data_q <= 8'h3E;
            7'h6B: data_q <= 8'hD0;
            7'h6C: data_q <= 8'h1C;
            7'h6D: data_q <= 8'h0B;
            7'h6E: data_q <= 8'h1D;
            7'h6F: data_q <= 8'h0C;
            7'h70: data_q <= 8'h00;
            7'h71: data_q <= 8'h00;
            7'h72: data_q <= 8'h1E;
            7'h73: data_q <= 8'hE8;
            7'h74: data_q <= 8'h12;
            7'h75: data_q <= 8'hE9;
            7'h76: data_q <= 8'h20;
            7'h77: data_q <= 8'hC1;
            7'h78: data_q <= 8'h02;
            7'h79: data_q <= 8'hEB;
            // the top six bytes are unused and read as zero.
            default: data_q <= '0;
        endcase
    end

    assign data = enable ? data_q : '0;

endmodule

`default_nettype wire

/* hdl/rom_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter, one ROM read granted per cycle.
module rom_arbiter (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire rom_pkg::rom_req_t          host_req,
    input  wire rom_pkg::rom_req_t          hdr_req,
    input  wire rom_pkg::rom_req_t          sum_req,
    output rom_pkg::rom_rsp_t               host_rsp,
    output rom_pkg::rom_rsp_t               hdr_rsp,
    output rom_pkg::rom_rsp_t               sum_rsp,
    output logic      [rom_pkg::ADDR_W-1:0] rom_addr,
    output logic                            rom_en,
    input  wire logic [rom_pkg::DATA_W-1:0] rom_data
);

    logic [2:0]                 req_valid;
    logic [rom_pkg::ADDR_W-1:0] req_addr [3];
    logic [2:0]                 eligible;
    logic                       grant_valid;
    rom_pkg::req_id_e           grant_id;
    rom_pkg::req_id_e           last_id;
    logic                       rd_valid;
    rom_pkg::req_id_e           rd_id;

    assign req_valid   = {sum_req.valid, hdr_req.valid, host_req.valid};
    assign req_addr[0] = host_req.addr;
    assign req_addr[1] = hdr_req.addr;
    assign req_addr[2] = sum_req.addr;

    // a requester with a read in flight still holds its request, so skip it.
    assign eligible = req_valid & ~(rd_valid ? (3'b001 << rd_id) : 3'b000);

    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_id    = last_id;
        for (int k = 1; k <= 3; k++) begin
            idx = (int'(last_id) + k) % 3;
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                grant_id    = rom_pkg::req_id_e'(idx);
            end
        end
    end

    assign rom_addr = req_addr[grant_id];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_id    <= rom_pkg::REQ_HOST;
            last_id  <= rom_pkg::REQ_SUM;
        end else begin
            rd_valid <= grant_valid;
            rd_id    <= grant_id;
            if (grant_valid) begin
                last_id <= grant_id;
            end
        end
    end

    assign rom_en        = rd_valid;
    assign host_rsp.valid = rd_valid && (rd_id == rom_pkg::REQ_HOST);
    assign hdr_rsp.valid  = rd_valid && (rd_id == rom_pkg::REQ_HDR);
    assign sum_rsp.valid  = rd_valid && (rd_id == rom_pkg::REQ_SUM);
    assign host_rsp.data  = rom_data;
    assign hdr_rsp.data   = rom_data;
    assign sum_rsp.data   = rom_data;

    property p_rsp_after_grant(logic v, rom_pkg::req_id_e id);
        @(posedge clk) disable iff (reset) v |-> $past(grant_valid && grant_id == id);
    endproperty

    a_one_rsp: assert property (@(posedge clk) disable iff (reset)
        $onehot0({host_rsp.valid, hdr_rsp.valid, sum_rsp.valid}));
    a_host_rsp: assert property (p_rsp_after_grant(host_rsp.valid, rom_pkg::REQ_HOST));
    a_hdr_rsp: assert property (p_rsp_after_grant(hdr_rsp.valid, rom_pkg::REQ_HDR));
    a_sum_rsp: assert property (p_rsp_after_grant(sum_rsp.valid, rom_pkg::REQ_SUM));

endmodule

`default_nettype wire

/* hdl/header_check.sv */
`timescale 1ns/1ps
`default_nettype none

// reads the four magic bytes once after reset and flags a match.
module header_check #(
    parameter logic [31:0] HEADER_MAGIC = 32'h4D52_5341
) (
    input  wire logic              clk,
    input  wire logic              reset,
    output rom_pkg::rom_req_t      req,
    input  wire rom_pkg::rom_rsp_t rsp,
    output logic                   header_done,
    output logic                   header_ok
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DONE
    } state_e;

    state_e     state;
    logic [1:0] idx;
    logic       match;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            idx   <= 2'd0;
            match <= 1'b1;
        end else begin
            case (state)
                IDLE: state <= READ;
                READ: begin
                    if (rsp.valid) begin
                        // byte 0 of the image is the least significant magic byte.
                        match <= match && (rsp.data == HEADER_MAGIC[8*idx +: 8]);
                        idx   <= idx + 2'd1;
                        if (idx == 2'd3) begin
                            state <= DONE;
                        end
                    end
                end
                default: state <= DONE;
            endcase
        end
    end

    assign req.valid   = (state == READ);
    assign req.addr    = rom_pkg::ADDR_W'(idx);
    assign header_done = (state == DONE);
    assign header_ok   = (state == DONE) && match;

    a_hdr_addr: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> req.addr < 4);

endmodule

`default_nettype wire

/* hdl/checksum_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// sums a wrapping range of ROM bytes modulo 256.
module checksum_engine (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       sum_start,
    input  wire logic [rom_pkg::ADDR_W-1:0] sum_base,
    input  wire logic [7:0]                 sum_len,
    output rom_pkg::rom_req_t               req,
    input  wire rom_pkg::rom_rsp_t          rsp,
    output logic                            sum_busy,
    output logic                            sum_done,
    output logic      [rom_pkg::DATA_W-1:0] sum_value
);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e                     state;
    logic [rom_pkg::ADDR_W-1:0] cur_addr;
    logic [7:0]                 remaining;
    logic [rom_pkg::DATA_W-1:0] acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cur_addr  <= '0;
            remaining <= '0;
            acc       <= '0;
            sum_done  <= 1'b0;
        end else begin
            sum_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sum_start) begin
                        cur_addr  <= sum_base;
                        remaining <= sum_len;
                        acc       <= '0;
                        state     <= RUN;
                    end
                end
                default: begin
                    if (rsp.valid) begin
                        acc       <= acc + rsp.data;
                        // the address wraps from 0x7F back to 0 by its width.
                        cur_addr  <= cur_addr + 1'b1;
                        remaining <= remaining - 8'd1;
                        if (remaining == 8'd1) begin
                            state    <= IDLE;
                            sum_done <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign sum_busy  = (state == RUN);
    assign sum_value = acc;
    assign req.valid = (state == RUN);
    assign req.addr  = cur_addr;

    a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(sum_done) |-> $past(sum_busy));
    a_req_busy: assert property (@(posedge clk) disable iff (reset) req.valid |-> sum_busy);

endmodule

`default_nettype wire

/* hdl/rom_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

// boot ROM shared by the host port, the header checker and the checksum engine.
module rom_subsystem #(
    parameter logic [31:0] HEADER_MAGIC = 32'h4D52_5341
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       host_req,
    input  wire logic [rom_pkg::ADDR_W-1:0] host_addr,
    output logic      [rom_pkg::DATA_W-1:0] host_rdata,
    output logic                            host_rvalid,
    input  wire logic                       sum_start,
    input  wire logic [rom_pkg::ADDR_W-1:0] sum_base,
    input  wire logic [7:0]                 sum_len,
    output logic                            sum_busy,
    output logic                            sum_done,
    output logic      [rom_pkg::DATA_W-1:0] sum_value,
    output logic                            header_done,
    output logic                            header_ok
);

    rom_pkg::rom_req_t          host_rom_req, hdr_req, sum_req;
    rom_pkg::rom_rsp_t          host_rom_rsp, hdr_rsp, sum_rsp;
    logic [rom_pkg::ADDR_W-1:0] rom_addr;
    logic [rom_pkg::DATA_W-1:0] rom_data;
    logic                       rom_en;

    assign host_rom_req.valid = host_req;
    assign host_rom_req.addr  = host_addr;
    assign host_rdata         = host_rom_rsp.data;
    assign host_rvalid        = host_rom_rsp.valid;

    rom_arbiter rom_arbiter_inst (
        .clk, .reset,
        .host_req(host_rom_req), .hdr_req, .sum_req,
        .host_rsp(host_rom_rsp), .hdr_rsp, .sum_rsp,
        .rom_addr, .rom_en, .rom_data
    );

    program_rom program_rom_inst (.clk, .enable(rom_en), .addr(rom_addr), .data(rom_data));

    header_check #(.HEADER_MAGIC(HEADER_MAGIC)) header_check_inst (
        .clk, .reset, .req(hdr_req), .rsp(hdr_rsp), .header_done, .header_ok
    );

    checksum_engine checksum_engine_inst (
        .clk, .reset, .sum_start, .sum_base, .sum_len,
        .req(sum_req), .rsp(sum_rsp),
        .sum_busy, .sum_done, .sum_value
    );

endmodule

`default_nettype wire

/* sim/tb_rom_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rom_subsystem;

    localparam logic [31:0] MAGIC = 32'h4D52_5341;
    localparam int READ_LIMIT = 20;

    logic       clk;
    logic       reset;
    logic       host_req;
    logic [6:0] host_addr;
    logic [7:0] host_rdata;
    logic       host_rvalid;
    logic       sum_start;
    logic [6:0] sum_base;
    logic [7:0] sum_len;
    logic       sum_busy;
    logic       sum_done;
    logic [7:0] sum_value;
    logic       header_done;
    logic       header_ok;

    int         value_errors = 0;
    int         protocol_errors = 0;
    int         timeouts = 0;
    integer     seed;
    logic [7:0] image [128];

    rom_subsystem #(.HEADER_MAGIC(MAGIC)) rom_subsystem_inst (
        .clk, .reset, .host_req, .host_addr, .host_rdata, .host_rvalid,
        .sum_start, .sum_base, .sum_len, .sum_busy, .sum_done, .sum_value,
        .header_done, .header_ok
    );

    always #5 clk = ~clk;

    // with all three peers asking, the host waits at most two cycles for a grant.
    host_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(host_req) |-> ##[1:3] host_rvalid)
        else begin
            protocol_errors++;
            $display("host read took longer than 3 cycles to complete");
        end
    rvalid_pulse: assert property (@(posedge clk) disable iff (reset)
        host_rvalid |=> !host_rvalid)
        else begin
            protocol_errors++;
            $display("host_rvalid stayed high for more than one cycle");
        end
    done_pulse: assert property (@(posedge clk) disable iff (reset) sum_done |=> !sum_done)
        else begin
            protocol_errors++;
            $display("sum_done stayed high for more than one cycle");
        end
    header_hold: assert property (@(posedge clk) disable iff (reset)
        header_done |=> header_done && $stable(header_ok))
        else begin
            protocol_errors++;
            $display("header result changed after header_done");
        end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (exp === got)
            else begin
                value_errors++;
                $display("[ERROR] %s: expected %h, got %h", name, exp, got);
            end
    endtask

    // called on a falling edge, returns on a falling edge with the request dropped.
    task automatic host_read(input logic [6:0] addr, output logic [7:0] data);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        data = '0;
        host_addr = addr;
        host_req = 1'b1;
        while (!seen && cycles < READ_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (host_rvalid) begin
                seen = 1'b1;
                data = host_rdata;
            end
        end
        host_req = 1'b0;
        if (!seen) begin
            timeouts++;
            $display("timeout: host read of address %h got no response", addr);
        end
        @(negedge clk);
    endtask

    task automatic pulse_start(input logic [6:0] base, input logic [7:0] len);
        sum_base = base;
        sum_len = len;
        sum_start = 1'b1;
        @(negedge clk);
        sum_start = 1'b0;
    endtask

    task automatic wait_sum_done(input int limit);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            seen = sum_done;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: checksum did not finish within %0d cycles", limit);
        end
    endtask

    // the range wraps from 0x7F back to 0 because the address is 7 bits wide.
    function automatic logic [7:0] expected_sum(input logic [6:0] base, input logic [7:0] len);
        logic [7:0] acc;
        logic [6:0] a;
        acc = '0;
        a = base;
        for (int i = 0; i < len; i++) begin
            acc = acc + image[a];
            a = a + 7'd1;
        end
        return acc;
    endfunction

    task automatic run_checksum(input logic [6:0] base, input logic [7:0] len);
        pulse_start(base, len);
        wait_sum_done(4 * 128 + 20);
        compare_value("sum_value", expected_sum(base, len), sum_value);
    endtask

    initial begin
        logic [7:0] data;
        logic [7:0] whole;
        logic [6:0] base;
        logic [7:0] len;
        logic [6:0] addr;
        int         cycles;
        clk = 1'b0;
        reset = 1'b1;
        host_req = 1'b0;
        host_addr = '0;
        sum_start = 1'b0;
        sum_base = '0;
        sum_len = '0;
        seed = 93;
        repeat (10) @(negedge clk);
        compare_value("host_rvalid", 0, host_rvalid);
        compare_value("header_done", 0, header_done);
        compare_value("header_ok", 0, header_ok);
        compare_value("sum_busy", 0, sum_busy);
        compare_value("sum_done", 0, sum_done);
        compare_value("sum_value", 0, sum_value);
        reset = 1'b0;

        cycles = 0;
        while (!header_done && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!header_done) begin
            timeouts++;
            $display("timeout: header check never finished");
        end
        compare_value("header_ok", 1, header_ok);

        // the whole image is read once through the host port and kept as reference.
        whole = '0;
        for (int a = 0; a < 128; a++) begin
            host_read(7'(a), image[a]);
            whole = whole + image[a];
        end
        compare_value("host_rdata", 8'h41, image[0]);
        compare_value("host_rdata", 8'h53, image[1]);
        compare_value("host_rdata", 8'h52, image[2]);
        compare_value("host_rdata", 8'h4D, image[3]);
        for (int a = 'h7A; a < 128; a++) begin
            compare_value("host_rdata", 0, image[a]);
        end

        for (int t = 0; t < 3; t++) begin
            base = 7'($random(seed));
            len = 8'($random(seed) & 'h7F) + 8'd1;
            run_checksum(base, len);
        end

        base = 7'h70 | 7'($random(seed) & 'h0F);
        len = 8'd32 + 8'($random(seed) & 'h1F);
        run_checksum(base, len);
        base = 7'($random(seed));
        run_checksum(base, 8'd128);
        compare_value("sum_value", whole, sum_value);

        base = 7'($random(seed));
        pulse_start(base, 8'd128);
        for (int t = 0; t < 8; t++) begin
            addr = 7'($random(seed));
            host_read(addr, data);
            compare_value("host_rdata", image[addr], data);
        end
        compare_value("sum_busy", 1, sum_busy);
        // a second command while busy must not disturb the first one.
        pulse_start(base + 7'd5, 8'd17);
        wait_sum_done(4 * 128 + 20);
        compare_value("sum_value", expected_sum(base, 8'd128), sum_value);

        repeat (5) @(negedge clk);
        $display("summary: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/rom_pkg.sv
rom/program_rom.sv
hdl/rom_arbiter.sv
hdl/header_check.sv
hdl/checksum_engine.sv
hdl/rom_subsystem.sv
sim/tb_rom_subsystem.sv

/* Bender.yml */
package:
  name: rom_subsystem

sources:
  - common/rom_pkg.sv
  - rom/program_rom.sv
  - hdl/rom_arbiter.sv
  - hdl/header_check.sv
  - hdl/checksum_engine.sv
  - hdl/rom_subsystem.sv
  - target: simulation
    files:
      - sim/tb_rom_subsystem.sv
